// ==== sources.f ====
hdl/conv_pkg.sv
hdl/weight_rom.sv
hdl/sample_window.sv
hdl/mac_unit.sv
hdl/conv_layer.sv
sim/conv_layer_checker.sv
sim/conv_layer_tb.sv

// ==== sim/conv_layer_tests.txt ====
# columns: window words 0 to 7 (word 0 loads first), yumi delay in cycles,
# expected output 0, expected output 1; all values signed decimal Q4.8
# all-zero windows give the bias
0 0 0 0 0 0 0 0 0 64 64
0 0 0 0 0 0 0 0 3 64 64
# constant windows and single impulses
256 256 256 256 256 256 256 256 2 224 224
-256 -256 -256 -256 -256 -256 -256 -256 1 -96 -96
256 0 0 0 0 0 0 0 0 192 64
0 0 0 0 0 0 0 256 4 64 96
0 0 0 0 256 0 0 0 2 -320 320
# saturation both ways
32767 -32768 32767 32767 -32768 32767 -32768 32767 5 32767 32767
-32768 32767 -32768 -32768 32767 -32768 32767 -32768 0 -32768 -32768
32767 -32768 0 32767 0 0 32767 -32768 3 32767 -32768
-32768 32767 0 -32768 0 0 -32768 32767 7 -32768 32767
0 0 32702 0 0 0 0 0 1 32766 16415
0 0 0 0 21846 0 0 0 0 -32705 21910
0 0 0 0 21890 0 0 0 2 -32768 21954
# small values, the right shift rounds toward minus infinity
0 0 0 0 0 -3 0 0 1 63 61
0 0 0 0 0 0 0 -515 0 64 -1
0 0 0 0 0 0 0 -521 4 64 -2
0 0 0 0 0 7 0 0 6 64 69
# random windows
300 -150 75 420 -90 1000 -250 60 1 901 1039
-1234 567 -89 2048 333 -777 1500 -42 0 155 -2998
5000 -3000 1200 -800 2500 100 -4000 7000 2 176 10314
-16000 12000 9000 -7000 -5000 30000 8000 -20000 3 4064 9314
17 -29 101 -3 58 -211 64 999 0 65 43
-25000 -25000 -25000 -25000 -25000 -25000 -25000 -25000 5 -15561 -15561
12345 -6789 2468 -1357 8642 -9753 1111 -2222 1 -4799 1020
-500 1800 -2600 3400 -4200 5000 -5800 6600 2 6239 6989
31000 200 -31000 150 400 -32000 9000 14000 0 -19974 -32768
-7 13 -19 23 -29 31 -37 41 6 102 103
9999 -9999 9999 -9999 9999 -9999 9999 -9999 1 -6186 -6186
2000 30000 4000 100 20000 700 -30000 25000 3 -32274 32767
256 512 768 1024 1280 1536 1792 2048 0 -128 192

// ==== sim/conv_layer_tb.sv ====
`default_nettype none

module conv_layer_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_HALF       = 2;
    localparam int DRIVE_DELAY    = 1;    // inputs change this long after the rising edge
    localparam int RESET_CYCLES   = 3;
    localparam int RESULT_TIMEOUT = 30;   // generous bound on cycles from start to valid_o
    localparam int CYCLES_PER_TEST = 40;
    localparam int FIELD_COUNT    = conv_pkg::WINDOW_WORDS + 1 + conv_pkg::OUT_COUNT;

    // one line of the tests file
    typedef struct packed {
        conv_pkg::window_t samples;    // word 0 is loaded first
        int                delay;      // cycles yumi_i stays low once valid_o is up
        conv_pkg::result_t expected;
    } test_vec_t;

    logic              clk_i = 1'b0;
    logic              reset_i;
    logic              sample_valid_i;
    conv_pkg::word_t   sample_i;
    logic              start_i;
    logic              ready_o;
    logic              valid_o;
    logic              yumi_i;
    conv_pkg::result_t data_o;

    test_vec_t   tests [$];
    logic        tests_loaded = 1'b0;
    int unsigned lcg_state = 32'd19369;

    conv_layer UUT (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .sample_valid_i (sample_valid_i),
        .sample_i       (sample_i),
        .start_i        (start_i),
        .ready_o        (ready_o),
        .valid_o        (valid_o),
        .yumi_i         (yumi_i),
        .data_o         (data_o)
    );

    always #CLK_HALF clk_i = ~clk_i;

    function automatic int unsigned next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state >> 8;   // low bits of an LCG repeat quickly
    endfunction

    function automatic logic random_bit();
        return (next_random() % 2) == 1;
    endfunction

    function automatic conv_pkg::word_t random_word();
        return conv_pkg::word_t'(next_random());
    endfunction

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Regression failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic next_cycle();
        @(posedge clk_i);
        #DRIVE_DELAY;
    endtask

    task automatic check_bit(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            abort_run($sformatf("FAIL at %0d ns: %s is %b, expected %b",
                                $time, what, actual, expected));
        end
    endtask

    task automatic check_result(input conv_pkg::result_t actual,
                                input conv_pkg::result_t expected,
                                input string what);
        if (actual !== expected) begin
            abort_run($sformatf("FAIL at %0d ns: %s is (%0d, %0d), expected (%0d, %0d)",
                                $time, what, actual.value[0], actual.value[1],
                                expected.value[0], expected.value[1]));
        end
    endtask

    // expected pairs follow conv_pkg::KERNEL_WEIGHTS and conv_pkg::KERNEL_BIAS
    // as the sum of full products plus bias << 8, then >>> 8 and saturation
    task automatic load_tests();
        int        fd;
        int        n;
        int        line_no;
        int        fields [FIELD_COUNT];
        string     line;
        test_vec_t t;
        fd = $fopen("sim/conv_layer_tests.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open the tests file sim/conv_layer_tests.txt");
        end
        line_no = 0;
        while ($fgets(line, fd) != 0) begin
            line_no++;
            if (line.len() == 0 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d",
                        fields[0], fields[1], fields[2], fields[3], fields[4], fields[5],
                        fields[6], fields[7], fields[8], fields[9], fields[10]);
            if (n <= 0) begin
                continue;   // blank line
            end
            if (n != FIELD_COUNT || fields[8] < 0) begin
                abort_run($sformatf("Line %0d of the tests file is malformed", line_no));
            end
            for (int k = 0; k < conv_pkg::WINDOW_WORDS; k++) begin
                t.samples[k] = conv_pkg::word_t'(fields[k]);
            end
            t.delay = fields[8];
            t.expected.value[0] = conv_pkg::word_t'(fields[9]);
            t.expected.value[1] = conv_pkg::word_t'(fields[10]);
            tests.push_back(t);
        end
        $fclose(fd);
        if (tests.size() == 0) begin
            abort_run("The tests file holds no tests");
        end
    endtask

    task automatic run_test(input test_vec_t t, input int index);
        conv_pkg::result_t held;
        int                gap;
        int                waited;
        string             tag;
        tag = $sformatf("test %0d", index);

        // oldest sample first with random idle gaps between strobes
        for (int k = 0; k < conv_pkg::WINDOW_WORDS; k++) begin
            gap = next_random() % 3;
            repeat (gap) next_cycle();
            sample_valid_i = 1'b1;
            sample_i       = t.samples[k];
            next_cycle();
            sample_valid_i = 1'b0;
            sample_i       = random_word();
        end

        start_i = 1'b1;
        next_cycle();
        start_i = 1'b0;
        check_bit(ready_o, 1'b0, {tag, " ready_o after start"});

        // stray starts, strobes and yumi pulses must all be ignored while busy
        waited = 0;
        while (!valid_o) begin
            if (waited == RESULT_TIMEOUT) begin
                abort_run($sformatf("valid_o never rose in %s after %0d cycles",
                                    tag, RESULT_TIMEOUT));
            end
            start_i        = random_bit();
            sample_valid_i = random_bit();
            sample_i       = random_word();
            yumi_i         = random_bit();
            next_cycle();
            waited++;
        end
        start_i        = 1'b0;
        sample_valid_i = 1'b0;
        yumi_i         = 1'b0;

        check_result(data_o, t.expected, {tag, " data_o"});
        held = data_o;

        // back-pressure with more junk on the inputs
        repeat (t.delay) begin
            start_i        = random_bit();
            sample_valid_i = random_bit();
            sample_i       = random_word();
            next_cycle();
            check_bit(valid_o, 1'b1, {tag, " valid_o under back-pressure"});
            check_result(data_o, held, {tag, " data_o under back-pressure"});
        end
        start_i        = 1'b0;
        sample_valid_i = 1'b0;

        yumi_i = 1'b1;
        next_cycle();
        yumi_i = 1'b0;
        check_bit(valid_o, 1'b0, {tag, " valid_o after yumi"});
        check_bit(ready_o, 1'b1, {tag, " ready_o after yumi"});
    endtask

    initial begin : watchdog
        int limit;
        wait (tests_loaded);
        limit = tests.size() * CYCLES_PER_TEST + 100;
        repeat (limit) @(posedge clk_i);
        abort_run($sformatf("Timeout: the run did not finish within %0d cycles", limit));
    end

    initial begin
        reset_i        = 1'b1;
        sample_valid_i = 1'b0;
        sample_i       = '0;
        start_i        = 1'b0;
        yumi_i         = 1'b0;

        load_tests();
        tests_loaded = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk_i);
        #DRIVE_DELAY;
        reset_i = 1'b0;
        check_bit(ready_o, 1'b1, "ready_o after reset");
        check_bit(valid_o, 1'b0, "valid_o after reset");
        check_result(data_o, '0, "data_o after reset");

        for (int i = 0; i < tests.size(); i++) begin
            run_test(tests[i], i);
        end

        if (UUT.u_checker.failure_count == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            abort_run($sformatf("The bound checker reported %0d assertion failures",
                                UUT.u_checker.failure_count));
        end
    end

endmodule

`default_nettype wire

// ==== sim/conv_layer_checker.sv ====
`default_nettype none

module conv_layer_checker (
    input wire logic              clk_i,
    input wire logic              reset_i,
    input wire logic              start_i,
    input wire logic              ready_i,
    input wire logic              valid_i,
    input wire logic              yumi_i,
    input wire conv_pkg::result_t data_i
);

    timeunit 1ns;
    timeprecision 100ps;

    // valid_o rises this many cycles after the start is sampled
    localparam int LATENCY      = conv_pkg::NUM_TAPS + 3;
    localparam int QUIET_CYCLES = LATENCY - 1;

    int failure_count = 0;   // number of failed assertions

    property ready_valid_exclusive;
        @(posedge clk_i) disable iff (reset_i)
            !(ready_i && valid_i);
    endproperty

    property hold_under_backpressure;
        @(posedge clk_i) disable iff (reset_i)
            (valid_i && !yumi_i) |=> (valid_i && $stable(data_i));
    endproperty

    // quiet while the taps run, then the result shows up
    property start_to_valid;
        @(posedge clk_i) disable iff (reset_i)
            (start_i && ready_i) |=> !valid_i [*QUIET_CYCLES] ##1 valid_i;
    endproperty

    property handshake_to_ready;
        @(posedge clk_i) disable iff (reset_i)
            (valid_i && yumi_i) |=> (ready_i && !valid_i);
    endproperty

    a_exclusive: assert property (ready_valid_exclusive) else begin
        failure_count++;
        $error("ready_o and valid_o are high in the same cycle");
    end

    a_hold: assert property (hold_under_backpressure) else begin
        failure_count++;
        $error("result changed or dropped while yumi_i was low");
    end

    a_latency: assert property (start_to_valid) else begin
        failure_count++;
        $error("valid_o did not rise %0d cycles after start", LATENCY);
    end

    a_handshake: assert property (handshake_to_ready) else begin
        failure_count++;
        $error("layer did not return to ready after the yumi handshake");
    end

endmodule

bind conv_layer conv_layer_checker u_checker (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .start_i (start_i),
    .ready_i (ready_o),
    .valid_i (valid_o),
    .yumi_i  (yumi_i),
    .data_i  (data_o)
);

`default_nettype wire

// ==== hdl/conv_layer.sv ====
`default_nettype none

module conv_layer (
    input  wire logic              clk_i,
    input  wire logic              reset_i,

    // sample stream into the window
    input  wire logic              sample_valid_i,
    input  wire conv_pkg::word_t   sample_i,

    // start of a computation
    input  wire logic              start_i,
    output logic                   ready_o,

    // result, held until taken
    output logic                   valid_o,
    input  wire logic              yumi_i,
    output conv_pkg::result_t      data_o
);

    conv_pkg::layer_state_e state_q, state_d;
    conv_pkg::tap_addr_t    tap_q;
    conv_pkg::window_t      window;
    conv_pkg::word_t        rom_data;
    conv_pkg::word_t        unit_result [conv_pkg::OUT_COUNT];

    logic last_tap;
    logic shift_en;
    logic sum_en_q;
    logic add_bias;
    logic clear;

    assign last_tap = (tap_q == conv_pkg::tap_addr_t'(conv_pkg::NUM_TAPS));
    assign clear    = valid_o && yumi_i;   // handshake empties the MACs

    // controller
    always_comb begin
        state_d = state_q;
        case (state_q)
            conv_pkg::READY: begin
                if (start_i) begin
                    state_d = conv_pkg::BUSY;
                end
            end
            conv_pkg::BUSY: begin
                // address NUM_TAPS is out, bias word lands next cycle
                if (last_tap) begin
                    state_d = conv_pkg::BIAS;
                end
            end
            conv_pkg::BIAS: begin
                state_d = conv_pkg::DONE;
            end
            conv_pkg::DONE: begin
                if (yumi_i) begin
                    state_d = conv_pkg::READY;
                end
            end
            default: begin
                state_d = conv_pkg::READY;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= conv_pkg::READY;
        end else begin
            state_q <= state_d;
        end
    end

    // tap counter walks 0..NUM_TAPS while busy, parked at 0 otherwise
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            tap_q <= '0;
        end else if (state_q == conv_pkg::BUSY && !last_tap) begin
            tap_q <= tap_q + 1'b1;
        end else begin
            tap_q <= '0;
        end
    end

    // weight reads lag the address by one cycle, so the enables do too
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            sum_en_q <= 1'b0;
        end else begin
            sum_en_q <= (state_q == conv_pkg::BUSY) && !last_tap;
        end
    end

    assign add_bias = (state_q == conv_pkg::BIAS);   // bias word is on rom_data now

    assign ready_o  = (state_q == conv_pkg::READY);
    assign valid_o  = (state_q == conv_pkg::DONE);
    assign shift_en = sample_valid_i && ready_o;   // window frozen outside READY

    sample_window u_window (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .shift_en_i (shift_en),
        .data_i     (sample_i),
        .window_o   (window)
    );

    weight_rom u_rom (
        .clk_i  (clk_i),
        .addr_i (tap_q),
        .data_o (rom_data)
    );

    for (genvar j = 0; j < conv_pkg::OUT_COUNT; j++) begin : g_unit
        conv_pkg::word_t sample_q;

        // unit j starts at row j, registered to line up with the ROM output
        always_ff @(posedge clk_i) begin
            if (int'(tap_q) < conv_pkg::NUM_TAPS) begin
                sample_q <= window[j * conv_pkg::KERNEL_WIDTH + int'(tap_q)];
            end
        end

        mac_unit u_mac (
            .clk_i      (clk_i),
            .reset_i    (reset_i),
            .clear_i    (clear),
            .sum_en_i   (sum_en_q),
            .add_bias_i (add_bias),
            .weight_i   (rom_data),
            .data_i     (sample_q),
            .result_o   (unit_result[j])
        );
    end

    always_comb begin
        for (int k = 0; k < conv_pkg::OUT_COUNT; k++) begin
            data_o.value[k] = unit_result[k];
        end
    end

endmodule

`default_nettype wire

// ==== hdl/mac_unit.sv ====
`default_nettype none

module mac_unit (
    input  wire logic            clk_i,
    input  wire logic            reset_i,
    input  wire logic            clear_i,
    input  wire logic            sum_en_i,
    input  wire logic            add_bias_i,
    input  wire conv_pkg::word_t weight_i,
    input  wire conv_pkg::word_t data_i,
    output conv_pkg::word_t      result_o
);

    logic signed [conv_pkg::ACC_BITS-1:0]    acc_q;
    logic signed [2*conv_pkg::WORD_SIZE-1:0] product;
    logic signed [conv_pkg::ACC_BITS-1:0]    biased;
    logic signed [conv_pkg::ACC_BITS-1:0]    scaled;
    conv_pkg::word_t                         saturated;

    // full precision Q8.16 product
    assign product = weight_i * data_i;

    // on the bias cycle weight_i carries the bias word
    assign biased = acc_q + (conv_pkg::ACC_BITS'(weight_i) <<< conv_pkg::FRAC_BITS);
    assign scaled = biased >>> conv_pkg::FRAC_BITS;   // back to Q4.8

    // clip to the 16 bit signed range when the upper bits disagree
    always_comb begin
        if (&scaled[conv_pkg::ACC_BITS-1:conv_pkg::WORD_SIZE-1] ||
            ~|scaled[conv_pkg::ACC_BITS-1:conv_pkg::WORD_SIZE-1]) begin
            saturated = scaled[conv_pkg::WORD_SIZE-1:0];
        end else if (scaled[conv_pkg::ACC_BITS-1]) begin
            saturated = {1'b1, {(conv_pkg::WORD_SIZE-1){1'b0}}};   // most negative
        end else begin
            saturated = {1'b0, {(conv_pkg::WORD_SIZE-1){1'b1}}};   // most positive
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i || clear_i) begin
            acc_q    <= '0;
            result_o <= '0;
        end else if (add_bias_i) begin
            result_o <= saturated;   // held until the next clear
        end else if (sum_en_i) begin
            acc_q <= acc_q + product;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/sample_window.sv ====
`default_nettype none

module sample_window (
    input  wire logic            clk_i,
    input  wire logic            reset_i,
    input  wire logic            shift_en_i,
    input  wire conv_pkg::word_t data_i,
    output conv_pkg::window_t    window_o
);

    conv_pkg::window_t window_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            window_q <= '0;
        end else if (shift_en_i) begin
            // everything moves one place toward word 0
            for (int k = 0; k < conv_pkg::WINDOW_WORDS - 1; k++) begin
                window_q[k] <= window_q[k+1];
            end
            window_q[conv_pkg::WINDOW_WORDS-1] <= data_i;   // newest sample
        end
    end

    assign window_o = window_q;

endmodule

`default_nettype wire

// ==== hdl/weight_rom.sv ====
`default_nettype none

module weight_rom (
    input  wire logic              clk_i,
    input  wire conv_pkg::tap_addr_t addr_i,
    output conv_pkg::word_t        data_o
);

    // registered read, one cycle of latency
    always_ff @(posedge clk_i) begin
        if (int'(addr_i) < conv_pkg::NUM_TAPS) begin
            data_o <= conv_pkg::KERNEL_WEIGHTS[addr_i];
        end else begin
            // address NUM_TAPS returns the bias word
            data_o <= conv_pkg::KERNEL_BIAS;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/conv_pkg.sv ====
`default_nettype none

package conv_pkg;

    // fixed-point format, Q4.8 samples and weights
    localparam int WORD_SIZE = 16;
    localparam int FRAC_BITS = 8;

    // window and kernel geometry
    localparam int INPUT_HEIGHT  = 4;
    localparam int KERNEL_HEIGHT = 3;
    localparam int KERNEL_WIDTH  = 2;   // I and Q channels
    localparam int NUM_TAPS      = KERNEL_HEIGHT * KERNEL_WIDTH;
    localparam int WINDOW_WORDS  = INPUT_HEIGHT * KERNEL_WIDTH;
    localparam int OUT_COUNT     = INPUT_HEIGHT - KERNEL_HEIGHT + 1;

    // tap address covers 0..NUM_TAPS, the last one selects the bias
    localparam int ADDR_BITS = $clog2(NUM_TAPS + 1);

    // wide enough for six full products plus the scaled bias
    localparam int ACC_BITS = 36;

    typedef logic signed [WORD_SIZE-1:0] word_t;
    typedef logic [ADDR_BITS-1:0] tap_addr_t;

    // word 0 is the oldest sample, word r*KERNEL_WIDTH+c is row r channel c
    typedef word_t [WINDOW_WORDS-1:0] window_t;

    typedef struct packed {
        word_t [OUT_COUNT-1:0] value;   // value[j] is output position j
    } result_t;

    // kernel taps in tap order, row major, I then Q
    localparam word_t KERNEL_WEIGHTS [NUM_TAPS] = '{
        16'sd128,   // 0.5
        -16'sd64,   // -0.25
        16'sd256,   // 1.0
        16'sd192,   // 0.75
        -16'sd384,  // -1.5
        16'sd32     // 0.125
    };

    localparam word_t KERNEL_BIAS = 16'sd64;   // 0.25

    // layer controller
    typedef enum logic [1:0] {
        READY = 2'b00,
        BUSY  = 2'b01,
        BIAS  = 2'b10,
        DONE  = 2'b11
    } layer_state_e;

endpackage

`default_nettype wire
